// File: hw/backend_top.sv
`timescale 1ns/10ps

module backend_top #(
    parameter int NUM_REGS  = 32,
    parameter int CNT_WIDTH = 32
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start_i,
    input  logic                                   stall_i,
    input  logic                                   flush_i,
    input  logic                                   valid_i,
    input  logic                                   is_ld_i,
    input  cpu_types_pkg::ld_size_t                ld_size_i,
    input  logic                                   ld_signed_i,
    input  cpu_types_pkg::u32_t                    ld_data_i,
    input  logic [1:0]                             addr_lo_i,
    input  cpu_types_pkg::u32_t                    alu_result_i,
    input  cpu_types_pkg::reg_idx_t                rd_i,
    input  logic                                   is_wr_rd_i,
    input  logic                                   is_link_i,
    input  cpu_types_pkg::u32_t                    pc_plus4_i,
    input  logic                                   is_trap_i,
    input  cpu_types_pkg::reg_idx_t                raddr_a_i,
    input  cpu_types_pkg::reg_idx_t                raddr_b_i,
    output logic                                   stall_o,
    output cpu_types_pkg::u32_t                    rdata_a_o,
    output cpu_types_pkg::u32_t                    rdata_b_o,
    output logic                                   reg_we_o,
    output logic                                   halted_o,
    output logic [cpu_consts_pkg::TRAP_CODE_W-1:0] trap_code_o,
    output logic [CNT_WIDTH-1:0]                   cycle_cnt_o,
    output logic [CNT_WIDTH-1:0]                   instr_cnt_o
);

    logic                    m2_valid;
    cpu_types_pkg::reg_idx_t m2_rd;
    logic                    m2_is_wr_rd;
    logic                    m2_is_link;
    cpu_types_pkg::u32_t     m2_pc_plus4;
    cpu_types_pkg::u32_t     m2_result;
    logic                    m2_is_trap;
    cpu_types_pkg::reg_idx_t wb_idx;
    cpu_types_pkg::u32_t     wb_data;
    logic                    commit;
    logic                    trap_commit;
    logic                    commit_en;

    assign stall_o = stall_i | ~commit_en; // Upstream waits until the core runs.

    mem2_stage u_mem2 (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i), .flush_i(flush_i),
        .valid_i(valid_i), .is_ld_i(is_ld_i), .ld_size_i(ld_size_i),
        .ld_signed_i(ld_signed_i), .ld_data_i(ld_data_i), .addr_lo_i(addr_lo_i),
        .alu_result_i(alu_result_i), .rd_i(rd_i), .is_wr_rd_i(is_wr_rd_i),
        .is_link_i(is_link_i), .pc_plus4_i(pc_plus4_i), .is_trap_i(is_trap_i),
        .valid_o(m2_valid), .rd_o(m2_rd), .is_wr_rd_o(m2_is_wr_rd),
        .is_link_o(m2_is_link), .pc_plus4_o(m2_pc_plus4), .result_o(m2_result),
        .is_trap_o(m2_is_trap)
    );

    writeback u_wb (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i), .flush_i(flush_i),
        .commit_en_i(commit_en), .valid_i(m2_valid), .rd_i(m2_rd),
        .is_wr_rd_i(m2_is_wr_rd), .is_link_i(m2_is_link), .pc_plus4_i(m2_pc_plus4),
        .result_i(m2_result), .is_trap_i(m2_is_trap), .reg_idx_o(wb_idx),
        .reg_we_o(reg_we_o), .reg_data_o(wb_data), .commit_o(commit),
        .trap_commit_o(trap_commit)
    );

    regfile #(.NUM_REGS(NUM_REGS)) u_rf (
        .clk(clk), .rst_n(rst_n), .we_i(reg_we_o), .waddr_i(wb_idx), .wdata_i(wb_data),
        .raddr_a_i(raddr_a_i), .raddr_b_i(raddr_b_i),
        .rdata_a_o(rdata_a_o), .rdata_b_o(rdata_b_o)
    );

    commit_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .start_i(start_i), .trap_commit_i(trap_commit),
        .commit_en_o(commit_en), .halted_o(halted_o), .trap_code_o(trap_code_o)
    );

    perf_counter #(.CNT_WIDTH(CNT_WIDTH)) u_perf (
        .clk(clk), .rst_n(rst_n), .run_i(commit_en), .commit_i(commit),
        .cycle_cnt_o(cycle_cnt_o), .instr_cnt_o(instr_cnt_o)
    );

endmodule

// File: hw/commit_ctrl.sv
`timescale 1ns/10ps

module commit_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start_i,
    input  logic                                   trap_commit_i,
    output logic                                   commit_en_o,
    output logic                                   halted_o,
    output logic [cpu_consts_pkg::TRAP_CODE_W-1:0] trap_code_o
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        HALT = 2'd2
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start_i) state_nxt = RUN;
            RUN:     if (trap_commit_i) state_nxt = HALT;
            default: state_nxt = HALT; // Only reset leaves HALT.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            trap_code_o <= '0;
        end else begin
            state <= state_nxt;
            if (trap_commit_i) begin
                trap_code_o <= cpu_consts_pkg::TRAP_CODE_HALT;
            end
        end
    end

    assign commit_en_o = (state == RUN);
    assign halted_o    = (state == HALT);

    // Writeback only commits while enabled, so a trap outside RUN means a broken gate.
    trap_in_run_chk: assert property (@(posedge clk) disable iff (!rst_n)
        trap_commit_i |-> (state == RUN));

endmodule

// File: hw/cpu_consts_pkg.sv
package cpu_consts_pkg;

    // The zero register reads as zero and drops every write.
    localparam cpu_types_pkg::reg_idx_t ZERO_REG = '0;

    localparam int TRAP_CODE_W = 8;

    // Code reported once the halting trap has committed.
    localparam logic [TRAP_CODE_W-1:0] TRAP_CODE_HALT = 8'h01;

endpackage

// File: hw/cpu_types_pkg.sv
package cpu_types_pkg;

    localparam int XLEN = 32;
    localparam int REG_IDX_W = 5;

    // Architectural register index.
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Data word moved through the back end.
    typedef logic [XLEN-1:0] u32_t;

    // Access size of a load, as decoded upstream.
    typedef enum logic [1:0] {
        LD_BYTE = 2'd0,
        LD_HALF = 2'd1,
        LD_WORD = 2'd2
    } ld_size_t;

endpackage

// File: hw/mem2_stage.sv
`timescale 1ns/10ps

module mem2_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic                    valid_i,
    input  logic                    is_ld_i,
    input  cpu_types_pkg::ld_size_t ld_size_i,
    input  logic                    ld_signed_i,
    input  cpu_types_pkg::u32_t     ld_data_i,
    input  logic [1:0]              addr_lo_i,
    input  cpu_types_pkg::u32_t     alu_result_i,
    input  cpu_types_pkg::reg_idx_t rd_i,
    input  logic                    is_wr_rd_i,
    input  logic                    is_link_i,
    input  cpu_types_pkg::u32_t     pc_plus4_i,
    input  logic                    is_trap_i,
    output logic                    valid_o,
    output cpu_types_pkg::reg_idx_t rd_o,
    output logic                    is_wr_rd_o,
    output logic                    is_link_o,
    output cpu_types_pkg::u32_t     pc_plus4_o,
    output cpu_types_pkg::u32_t     result_o,
    output logic                    is_trap_o
);

    logic                    is_ld_q;
    cpu_types_pkg::ld_size_t ld_size_q;
    logic                    ld_signed_q;
    cpu_types_pkg::u32_t     ld_data_q;
    logic [1:0]              addr_lo_q;
    cpu_types_pkg::u32_t     alu_result_q;
    cpu_types_pkg::u32_t     ld_shifted;
    cpu_types_pkg::u32_t     ld_aligned;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0; // Flush takes priority over stall.
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            is_ld_q      <= is_ld_i;
            ld_size_q    <= ld_size_i;
            ld_signed_q  <= ld_signed_i;
            ld_data_q    <= ld_data_i;
            addr_lo_q    <= addr_lo_i;
            alu_result_q <= alu_result_i;
            rd_o         <= rd_i;
            is_wr_rd_o   <= is_wr_rd_i;
            is_link_o    <= is_link_i;
            pc_plus4_o   <= pc_plus4_i;
            is_trap_o    <= is_trap_i;
        end
    end

    assign ld_shifted = ld_data_q >> {addr_lo_q, 3'b000}; // Bring the addressed lane to bit 0.

    always_comb begin
        case (ld_size_q)
            cpu_types_pkg::LD_BYTE:
                ld_aligned = {{24{ld_signed_q & ld_shifted[7]}}, ld_shifted[7:0]};
            cpu_types_pkg::LD_HALF:
                ld_aligned = {{16{ld_signed_q & ld_shifted[15]}}, ld_shifted[15:0]};
            default:
                ld_aligned = ld_shifted;
        endcase
    end

    assign result_o = is_ld_q ? ld_aligned : alu_result_q;

    // Misaligned loads are split upstream, so none may reach this stage.
    ld_align_chk: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_o && is_ld_q) |->
            ((ld_size_q != cpu_types_pkg::LD_HALF) || !addr_lo_q[0]) &&
            ((ld_size_q != cpu_types_pkg::LD_WORD) || (addr_lo_q == 2'b00)));

endmodule

// File: hw/perf_counter.sv
`timescale 1ns/10ps

module perf_counter #(
    parameter int CNT_WIDTH = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run_i,
    input  logic                 commit_i,
    output logic [CNT_WIDTH-1:0] cycle_cnt_o,
    output logic [CNT_WIDTH-1:0] instr_cnt_o
);

    // Both counters stick at all ones rather than wrap.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt_o <= '0;
            instr_cnt_o <= '0;
        end else begin
            if (run_i && (cycle_cnt_o != '1)) begin
                cycle_cnt_o <= cycle_cnt_o + 1'b1;
            end
            if (commit_i && (instr_cnt_o != '1)) begin
                instr_cnt_o <= instr_cnt_o + 1'b1;
            end
        end
    end

endmodule

// File: hw/regfile.sv
`timescale 1ns/10ps

module regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we_i,
    input  cpu_types_pkg::reg_idx_t waddr_i,
    input  cpu_types_pkg::u32_t     wdata_i,
    input  cpu_types_pkg::reg_idx_t raddr_a_i,
    input  cpu_types_pkg::reg_idx_t raddr_b_i,
    output cpu_types_pkg::u32_t     rdata_a_o,
    output cpu_types_pkg::u32_t     rdata_b_o
);

    cpu_types_pkg::u32_t regs [NUM_REGS];

    function automatic cpu_types_pkg::u32_t read_port(input cpu_types_pkg::reg_idx_t idx);
        if (idx < NUM_REGS) begin
            return regs[idx];
        end
        return '0; // Indices past the last register read as zero.
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != cpu_consts_pkg::ZERO_REG) && (waddr_i < NUM_REGS)) begin
            regs[waddr_i] <= wdata_i; // r0 is never written, so it stays zero.
        end
    end

    assign rdata_a_o = read_port(raddr_a_i);
    assign rdata_b_o = read_port(raddr_b_i);

    waddr_range_chk: assert property (@(posedge clk) disable iff (!rst_n)
        we_i |-> (waddr_i < NUM_REGS));

endmodule

// File: hw/writeback.sv
`timescale 1ns/10ps

module writeback (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic                    commit_en_i,
    input  logic                    valid_i,
    input  cpu_types_pkg::reg_idx_t rd_i,
    input  logic                    is_wr_rd_i,
    input  logic                    is_link_i,
    input  cpu_types_pkg::u32_t     pc_plus4_i,
    input  cpu_types_pkg::u32_t     result_i,
    input  logic                    is_trap_i,
    output cpu_types_pkg::reg_idx_t reg_idx_o,
    output logic                    reg_we_o,
    output cpu_types_pkg::u32_t     reg_data_o,
    output logic                    commit_o,
    output logic                    trap_commit_o
);

    logic                valid_q;
    logic                is_wr_rd_q;
    logic                is_link_q;
    cpu_types_pkg::u32_t pc_plus4_q;
    cpu_types_pkg::u32_t result_q;
    logic                is_trap_q;
    logic                fire;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            reg_idx_o  <= rd_i;
            is_wr_rd_q <= is_wr_rd_i;
            is_link_q  <= is_link_i;
            pc_plus4_q <= pc_plus4_i;
            result_q   <= result_i;
            is_trap_q  <= is_trap_i;
        end
    end

    // A held instruction retires only on the cycle the stall lifts.
    assign fire = valid_q & commit_en_i & ~stall_i;

    assign reg_data_o    = is_link_q ? pc_plus4_q : result_q; // Link writes the return address.
    assign reg_we_o      = fire & is_wr_rd_q;
    assign commit_o      = fire;
    assign trap_commit_o = fire & is_trap_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_backend --Mdir obj_dir -o tb_backend_sim

./obj_dir/tb_backend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
grep -q "test passed" sim.log

// File: src.f
+incdir+verif
hw/cpu_types_pkg.sv
hw/cpu_consts_pkg.sv
hw/mem2_stage.sv
hw/writeback.sv
hw/regfile.sv
hw/commit_ctrl.sv
hw/perf_counter.sv
hw/backend_top.sv
verif/tb_backend.sv

// File: verif/tb_backend_tests.svh
// Reset holds for two cycles, then a one-cycle start pulse moves the core to RUN.
task automatic reset_and_start();
    @(posedge clk);
    rst_n <= 1'b0;
    valid_i <= 1'b0;
    stall_i <= 1'b0;
    flush_i <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("stall_o", stall_o, 1'b1);
    check_flag("halted_o", halted_o, 1'b0);
    check_cnt("cycle_cnt_o", cycle_cnt_o, '0);
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    @(negedge clk);
    check_flag("stall_o", stall_o, 1'b0);
endtask

task automatic send(input logic ld, input cpu_types_pkg::ld_size_t size, input logic sgn,
                    input cpu_types_pkg::u32_t ldata, input logic [1:0] off,
                    input cpu_types_pkg::u32_t alu, input cpu_types_pkg::reg_idx_t rd,
                    input logic link, input cpu_types_pkg::u32_t pc, input logic trap);
    @(posedge clk);
    valid_i <= 1'b1;
    is_ld_i <= ld;
    ld_size_i <= size;
    ld_signed_i <= sgn;
    ld_data_i <= ldata;
    addr_lo_i <= off;
    alu_result_i <= alu;
    rd_i <= rd;
    is_wr_rd_i <= 1'b1;
    is_link_i <= link;
    pc_plus4_i <= pc;
    is_trap_i <= trap;
endtask

task automatic send_alu(input cpu_types_pkg::reg_idx_t rd, input cpu_types_pkg::u32_t val);
    send(1'b0, cpu_types_pkg::LD_WORD, 1'b0, '0, 2'b00, val, rd, 1'b0, '0, 1'b0);
endtask

// The last instruction reaches the register file two edges after it is sampled.
task automatic drain(input int n);
    @(posedge clk);
    valid_i <= 1'b0;
    repeat (n - 1) @(posedge clk);
endtask

task automatic expect_reg(input cpu_types_pkg::reg_idx_t idx, input cpu_types_pkg::u32_t exp);
    @(posedge clk);
    raddr_a_i <= idx;
    raddr_b_i <= idx;
    @(negedge clk);
    check_word($sformatf("rdata_a_o[r%0d]", idx), rdata_a_o, exp);
    check_word($sformatf("rdata_b_o[r%0d]", idx), rdata_b_o, exp);
endtask

function automatic cpu_types_pkg::u32_t expected_load(input cpu_types_pkg::u32_t data,
        input int off, input cpu_types_pkg::ld_size_t size, input logic sgn);
    logic [7:0]  b;
    logic [15:0] h;
    b = data[8*off +: 8];
    h = data[8*off +: 16];
    if (size == cpu_types_pkg::LD_BYTE) begin
        return (sgn && b[7]) ? {24'hffffff, b} : {24'h0, b};
    end else if (size == cpu_types_pkg::LD_HALF) begin
        return (sgn && h[15]) ? {16'hffff, h} : {16'h0, h};
    end
    return data;
endfunction

task automatic test_alu_writeback();
    cpu_types_pkg::u32_t vals [6];
    begin_test();
    reset_and_start();
    for (int i = 0; i < 6; i++) begin
        vals[i] = $urandom;
        send_alu(cpu_types_pkg::reg_idx_t'(5 * i + 1), vals[i]);
    end
    drain(3);
    for (int i = 0; i < 6; i++) begin
        expect_reg(cpu_types_pkg::reg_idx_t'(5 * i + 1), vals[i]);
    end
    end_test("alu_writeback");
endtask

task automatic test_link_select();
    cpu_types_pkg::u32_t pc;
    pc = $urandom & 32'hffff_fffc;
    begin_test();
    reset_and_start();
    send(1'b0, cpu_types_pkg::LD_WORD, 1'b0, '0, 2'b00, $urandom, 7, 1'b1, pc, 1'b0);
    drain(3);
    expect_reg(7, pc);
    end_test("link_select");
endtask

task automatic test_load_align();
    cpu_types_pkg::ld_size_t sizes [3];
    cpu_types_pkg::u32_t     data;
    sizes[0] = cpu_types_pkg::LD_BYTE;
    sizes[1] = cpu_types_pkg::LD_HALF;
    sizes[2] = cpu_types_pkg::LD_WORD;
    begin_test();
    reset_and_start();
    for (int s = 0; s < 3; s++) begin
        for (int off = 0; off < 4; off++) begin
            for (int sg = 0; sg < 2; sg++) begin
                if ((s == 1 && off[0]) || (s == 2 && off != 0)) begin
                    continue;
                end
                data = $urandom;
                send(1'b1, sizes[s], sg[0], data, off[1:0], $urandom, 9, 1'b0, '0, 1'b0);
                drain(3);
                expect_reg(9, expected_load(data, off, sizes[s], sg[0]));
            end
        end
    end
    end_test("load_align");
endtask

task automatic test_zero_reg();
    begin_test();
    reset_and_start();
    send_alu(cpu_consts_pkg::ZERO_REG, $urandom | 32'h1);
    drain(3);
    expect_reg(cpu_consts_pkg::ZERO_REG, '0);
    end_test("zero_reg");
endtask

task automatic test_stall_flush();
    cpu_types_pkg::u32_t vals [4];
    int                  start_count;
    begin_test();
    reset_and_start();
    start_count = we_count;
    for (int i = 0; i < 4; i++) begin
        vals[i] = $urandom;
    end
    send_alu(10, vals[0]);
    send_alu(11, vals[1]);
    @(posedge clk);
    valid_i <= 1'b0;
    stall_i <= 1'b1; // Both stages hold r10 and r11 here.
    @(negedge clk);
    check_flag("stall_o", stall_o, 1'b1);
    repeat (2) @(posedge clk);
    stall_i <= 1'b0;
    send_alu(12, vals[2]);
    send_alu(13, vals[3]);
    drain(3);
    check_cnt("write count", CNT_W'(we_count - start_count), 4);
    for (int i = 0; i < 4; i++) begin
        expect_reg(cpu_types_pkg::reg_idx_t'(10 + i), vals[i]);
    end
    start_count = we_count;
    send_alu(20, $urandom | 32'h1);
    send_alu(21, $urandom | 32'h1);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    valid_i <= 1'b0;
    repeat (3) @(posedge clk);
    check_cnt("flushed write count", CNT_W'(we_count - start_count), 0);
    expect_reg(20, '0);
    expect_reg(21, '0);
    end_test("stall_flush");
endtask

task automatic test_trap();
    cpu_types_pkg::u32_t vals [5];
    logic [CNT_W-1:0]    run_cycles;
    int                  waited;
    begin_test();
    reset_and_start();
    for (int i = 0; i < 5; i++) begin
        vals[i] = $urandom;
    end
    run_cycles = 7; // Five sends, the drain edge and the trap's commit edge.
    for (int i = 0; i < 3; i++) begin
        send_alu(cpu_types_pkg::reg_idx_t'(i + 1), vals[i]);
    end
    send(1'b0, cpu_types_pkg::LD_WORD, 1'b0, '0, 2'b00, vals[3], 4, 1'b0, '0, 1'b1);
    send_alu(5, vals[4]);
    drain(1);
    waited = 0;
    while (!halted_o && waited < 20) begin
        @(negedge clk);
        waited++;
    end
    if (!halted_o) begin
        $display("Trap test: the core did not halt after the trap instruction.");
        errors++;
    end
    check_code("trap_code_o", trap_code_o, cpu_consts_pkg::TRAP_CODE_HALT);
    check_cnt("instr_cnt_o", instr_cnt_o, 4);
    check_cnt("cycle_cnt_o", cycle_cnt_o, run_cycles);
    repeat (5) @(posedge clk);
    @(negedge clk);
    check_cnt("cycle_cnt_o", cycle_cnt_o, run_cycles);
    check_cnt("instr_cnt_o", instr_cnt_o, 4);
    check_flag("stall_o", stall_o, 1'b1);
    expect_reg(4, vals[3]);
    expect_reg(5, '0);
    check_idx("rd of dropped write", UUT.wb_idx, 5);
    end_test("trap");
endtask

// File: verif/tb_backend.sv
`timescale 1ns/10ps

module tb_backend;

    localparam int NUM_REGS  = 32;
    localparam int CNT_W     = 32;
    localparam int NUM_TESTS = 6;
    localparam int CLK_NS    = 4;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   start_i;
    logic                                   stall_i;
    logic                                   flush_i;
    logic                                   valid_i;
    logic                                   is_ld_i;
    cpu_types_pkg::ld_size_t                ld_size_i;
    logic                                   ld_signed_i;
    cpu_types_pkg::u32_t                    ld_data_i;
    logic [1:0]                             addr_lo_i;
    cpu_types_pkg::u32_t                    alu_result_i;
    cpu_types_pkg::reg_idx_t                rd_i;
    logic                                   is_wr_rd_i;
    logic                                   is_link_i;
    cpu_types_pkg::u32_t                    pc_plus4_i;
    logic                                   is_trap_i;
    cpu_types_pkg::reg_idx_t                raddr_a_i;
    cpu_types_pkg::reg_idx_t                raddr_b_i;
    logic                                   stall_o;
    cpu_types_pkg::u32_t                    rdata_a_o;
    cpu_types_pkg::u32_t                    rdata_b_o;
    logic                                   reg_we_o;
    logic                                   halted_o;
    logic [cpu_consts_pkg::TRAP_CODE_W-1:0] trap_code_o;
    logic [CNT_W-1:0]                       cycle_cnt_o;
    logic [CNT_W-1:0]                       instr_cnt_o;

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    int we_count;

    backend_top #(.NUM_REGS(NUM_REGS), .CNT_WIDTH(CNT_W)) UUT (
        .clk(clk), .rst_n(rst_n), .start_i(start_i), .stall_i(stall_i), .flush_i(flush_i),
        .valid_i(valid_i), .is_ld_i(is_ld_i), .ld_size_i(ld_size_i),
        .ld_signed_i(ld_signed_i), .ld_data_i(ld_data_i), .addr_lo_i(addr_lo_i),
        .alu_result_i(alu_result_i), .rd_i(rd_i), .is_wr_rd_i(is_wr_rd_i),
        .is_link_i(is_link_i), .pc_plus4_i(pc_plus4_i), .is_trap_i(is_trap_i),
        .raddr_a_i(raddr_a_i), .raddr_b_i(raddr_b_i), .stall_o(stall_o),
        .rdata_a_o(rdata_a_o), .rdata_b_o(rdata_b_o), .reg_we_o(reg_we_o),
        .halted_o(halted_o), .trap_code_o(trap_code_o), .cycle_cnt_o(cycle_cnt_o),
        .instr_cnt_o(instr_cnt_o)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Register writes are counted away from the active edge.
    always @(negedge clk) begin
        if (rst_n && reg_we_o) begin
            we_count++;
        end
    end

    task automatic check_word(input string name, input cpu_types_pkg::u32_t got,
                              input cpu_types_pkg::u32_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_idx(input string name, input cpu_types_pkg::reg_idx_t got,
                             input cpu_types_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cnt(input string name, input logic [CNT_W-1:0] got,
                             input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_code(input string name,
                              input logic [cpu_consts_pkg::TRAP_CODE_W-1:0] got,
                              input logic [cpu_consts_pkg::TRAP_CODE_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - test_errors);
        end
    endtask

    `include "tb_backend_tests.svh"

    initial begin
        #(NUM_TESTS * 200 * CLK_NS);
        $display("Timeout: the tests did not finish in time.");
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h4870b969));
        clk = 1'b0;
        rst_n = 1'b0;
        start_i = 1'b0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        valid_i = 1'b0;
        is_ld_i = 1'b0;
        ld_size_i = cpu_types_pkg::LD_WORD;
        ld_signed_i = 1'b0;
        ld_data_i = '0;
        addr_lo_i = 2'b00;
        alu_result_i = '0;
        rd_i = '0;
        is_wr_rd_i = 1'b0;
        is_link_i = 1'b0;
        pc_plus4_i = '0;
        is_trap_i = 1'b0;
        raddr_a_i = '0;
        raddr_b_i = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        we_count = 0;

        test_alu_writeback();
        test_link_select();
        test_load_align();
        test_zero_reg();
        test_stall_flush();
        test_trap();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
